/* hw/cpuPkg.sv */
package cpuPkg;

    localparam int dataWidth = 32;  // bus, register and memory word width

    // --------------------------------------------------
    // instruction format
    // --------------------------------------------------
    typedef enum logic [4:0] {
        opHalt  = 5'd0,  // zero word stops the run
        opAdd   = 5'd1,
        opSub   = 5'd2,
        opAnd   = 5'd3,
        opOr    = 5'd4,
        opAddi  = 5'd5,
        opLoad  = 5'd6,
        opStore = 5'd7
    } opcodeT;

    // rc overlays the top four bits of immediate, see registerBus
    typedef struct packed {
        opcodeT      opcode;     // [31:27]
        logic [3:0]  ra;         // [26:23] destination or store source
        logic [3:0]  rb;         // [22:19] base or first operand
        logic [18:0] immediate;  // [18:0] sign extended, rc in [18:15]
    } instructionT;

    // --------------------------------------------------
    // control word
    // --------------------------------------------------
    typedef enum logic [2:0] {
        srcNone      = 3'd0,  // bus reads zero
        srcRa        = 3'd1,
        srcRb        = 3'd2,
        srcRc        = 3'd3,
        srcMdr       = 3'd4,
        srcZlo       = 3'd5,
        srcPc        = 3'd6,
        srcImmediate = 3'd7
    } busSourceT;

    typedef enum logic [1:0] {
        aluAdd = 2'd0,
        aluSub = 2'd1,
        aluAnd = 2'd2,
        aluOr  = 2'd3
    } aluOpT;

    typedef enum logic [1:0] {
        selRa = 2'd0,
        selRb = 2'd1,
        selRc = 2'd2
    } regSelectT;

    typedef struct packed {
        busSourceT busSource;      // single bus driver
        logic      registerIn;     // write addressed register from bus
        regSelectT registerSelect; // which field addresses the write
        logic      yIn;
        logic      zIn;
        aluOpT     aluOp;
        logic      incPc;          // z takes bus plus one
        logic      pcIn;
        logic      marIn;
        logic      mdrIn;
        logic      mdrFromMemory;  // mdr loads memReadData instead of bus
        logic      irIn;
        logic      memRead;        // registered in memoryPort
        logic      memWrite;       // registered in memoryPort
    } controlWordT;

    // --------------------------------------------------
    // sequencer steps
    // --------------------------------------------------
    typedef enum logic [3:0] {
        stepIdle = 4'd0,
        stepT0   = 4'd1,
        stepT1   = 4'd2,
        stepT2   = 4'd3,
        stepT3   = 4'd4,
        stepT4   = 4'd5,
        stepT5   = 4'd6,
        stepT6   = 4'd7,
        stepT7   = 4'd8,
        stepT8   = 4'd9,
        stepT9   = 4'd10  // last step of load
    } stepT;

endpackage

/* hw/controlSequencer.sv */
`timescale 1ns/1ns
module controlSequencer import cpuPkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        start,
    input  instructionT instruction,
    output controlWordT control,
    output logic        busy,
    output logic        done
);

    stepT  step;       // current step
    stepT  nextStep;
    logic  isAluReg;   // add, sub, and, or
    logic  isAddi;
    logic  isLoad;
    logic  isStore;
    logic  isHaltLike; // halt and any unused encoding
    aluOpT aluSelect;

    // --------------------------------------------------
    // opcode decode
    // --------------------------------------------------
    always_comb begin
        isAluReg  = 1'b0;
        isAddi    = 1'b0;
        isLoad    = 1'b0;
        isStore   = 1'b0;
        aluSelect = aluAdd;
        case (instruction.opcode)
            opAdd:   isAluReg = 1'b1;
            opSub: begin
                isAluReg  = 1'b1;
                aluSelect = aluSub;
            end
            opAnd: begin
                isAluReg  = 1'b1;
                aluSelect = aluAnd;
            end
            opOr: begin
                isAluReg  = 1'b1;
                aluSelect = aluOr;
            end
            opAddi:  isAddi  = 1'b1;
            opLoad:  isLoad  = 1'b1;
            opStore: isStore = 1'b1;
            default: ;
        endcase
        isHaltLike = !(isAluReg || isAddi || isLoad || isStore);
    end

    // --------------------------------------------------
    // step sequencing
    // --------------------------------------------------
    always_comb begin
        case (step)
            stepIdle: nextStep = start ? stepT0 : stepIdle;
            stepT0:   nextStep = stepT1;
            stepT1:   nextStep = stepT2;
            stepT2:   nextStep = stepT3;
            stepT3:   nextStep = stepT4;
            stepT4:   nextStep = isHaltLike ? stepIdle : stepT5;
            stepT5:   nextStep = stepT6;
            stepT6:   nextStep = (isLoad || isStore) ? stepT7 : stepT0;
            stepT7:   nextStep = stepT8;
            stepT8:   nextStep = isLoad ? stepT9 : stepT0;  // store ends here
            default:  nextStep = stepT0;                    // T9 closes load
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            step <= stepIdle;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            step <= nextStep;
            done <= (step == stepT4) && isHaltLike;  // one cycle, lands in idle
            if (step == stepIdle && start)
                busy <= 1'b1;
            else if (step == stepT4 && isHaltLike)
                busy <= 1'b0;
        end
    end

    // --------------------------------------------------
    // control word per step
    // memRead and memWrite go out one cycle later from memoryPort,
    // so they are raised in the step before the memory cycle
    // --------------------------------------------------
    always_comb begin
        control = '0;
        case (step)
            stepT0: begin
                control.busSource = srcPc;   // pc to mar, pc plus one to z
                control.marIn     = 1'b1;
                control.zIn       = 1'b1;
                control.incPc     = 1'b1;
                control.memRead   = 1'b1;    // read seen in T1
            end
            stepT1: begin
                control.busSource = srcZlo;  // pc advances
                control.pcIn      = 1'b1;
            end
            stepT2: begin
                control.mdrIn         = 1'b1;  // instruction word arrives
                control.mdrFromMemory = 1'b1;
            end
            stepT3: begin
                control.busSource = srcMdr;
                control.irIn      = 1'b1;
            end
            stepT4: begin
                if (!isHaltLike) begin
                    control.busSource = srcRb;  // first operand or base to y
                    control.yIn       = 1'b1;
                end
            end
            stepT5: begin
                control.busSource = isAluReg ? srcRc : srcImmediate;
                control.aluOp     = isAluReg ? aluSelect : aluAdd;
                control.zIn       = 1'b1;
            end
            stepT6: begin
                control.busSource = srcZlo;
                if (isLoad || isStore) begin
                    control.marIn   = 1'b1;      // effective address
                    control.memRead = isLoad;    // load read seen in T7
                end else begin
                    control.registerIn     = 1'b1;
                    control.registerSelect = selRa;
                end
            end
            stepT7: begin
                if (isStore) begin
                    control.busSource = srcRa;   // store data to mdr
                    control.mdrIn     = 1'b1;
                    control.memWrite  = 1'b1;    // write seen in T8
                end
            end
            stepT8: begin
                if (isLoad) begin
                    control.mdrIn         = 1'b1;
                    control.mdrFromMemory = 1'b1;
                end
            end
            stepT9: begin
                control.busSource      = srcMdr; // loaded word to ra
                control.registerIn     = 1'b1;
                control.registerSelect = selRa;
            end
            default: ;
        endcase
    end

endmodule

/* hw/registerBus.sv */
`timescale 1ns/1ns
module registerBus import cpuPkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  controlWordT          control,
    input  instructionT          instruction,
    input  logic [dataWidth-1:0] zLow,
    input  logic [dataWidth-1:0] mdrValue,
    input  logic [dataWidth-1:0] pc,
    output logic [dataWidth-1:0] bus
);

    logic [dataWidth-1:0] registers [16];  // general registers r0..r15
    logic [3:0]           rcField;
    logic [3:0]           writeAddress;
    logic [dataWidth-1:0] immediateValue;

    assign rcField        = instruction.immediate[18:15];  // rc shares the top of imm
    assign immediateValue = {{(dataWidth - 19){instruction.immediate[18]}},
                             instruction.immediate};

    always_comb begin
        case (control.registerSelect)
            selRb:   writeAddress = instruction.rb;
            selRc:   writeAddress = rcField;
            default: writeAddress = instruction.ra;
        endcase
    end

    // --------------------------------------------------
    // bus source mux
    // --------------------------------------------------
    always_comb begin
        case (control.busSource)
            srcRa:        bus = registers[instruction.ra];
            srcRb:        bus = registers[instruction.rb];
            srcRc:        bus = registers[rcField];
            srcMdr:       bus = mdrValue;
            srcZlo:       bus = zLow;
            srcPc:        bus = pc;
            srcImmediate: bus = immediateValue;
            default:      bus = '0;  // srcNone
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 16; i++)
                registers[i] <= '0;
        end else if (control.registerIn) begin
            registers[writeAddress] <= bus;
        end
    end

endmodule

/* hw/aluUnit.sv */
`timescale 1ns/1ns
module aluUnit import cpuPkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  controlWordT          control,
    input  logic [dataWidth-1:0] bus,
    output logic [dataWidth-1:0] zLow
);

    logic [dataWidth-1:0] y;          // left operand held from an earlier step
    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] zNext;

    // --------------------------------------------------
    // operations, all wrap modulo 2**32
    // --------------------------------------------------
    always_comb begin
        case (control.aluOp)
            aluSub:  aluResult = y - bus;
            aluAnd:  aluResult = y & bus;
            aluOr:   aluResult = y | bus;
            default: aluResult = y + bus;
        endcase
    end

    // pc increment bypasses y entirely
    assign zNext = control.incPc ? bus + 1'b1 : aluResult;

    // --------------------------------------------------
    // y and z registers
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset)
            y <= '0;
        else if (control.yIn)
            y <= bus;
    end

    always_ff @(posedge clock) begin
        if (reset)
            zLow <= '0;
        else if (control.zIn)
            zLow <= zNext;  // read back on the bus as srcZlo
    end

endmodule

/* hw/memoryPort.sv */
`timescale 1ns/1ns
module memoryPort import cpuPkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  controlWordT          control,
    input  logic [dataWidth-1:0] bus,
    input  logic [dataWidth-1:0] memReadData,
    output logic [dataWidth-1:0] mdrValue,
    output logic [dataWidth-1:0] memAddress,
    output logic [dataWidth-1:0] memWriteData,
    output logic                 memRead,
    output logic                 memWrite
);

    logic [dataWidth-1:0] mar;
    logic [dataWidth-1:0] mdr;
    logic [dataWidth-1:0] mdrNext;

    assign mdrNext = control.mdrFromMemory ? memReadData : bus;

    always_ff @(posedge clock) begin
        if (reset) begin
            mar <= '0;
            mdr <= '0;
        end else begin
            if (control.marIn)
                mar <= bus;
            if (control.mdrIn)
                mdr <= mdrNext;
        end
    end

    // --------------------------------------------------
    // memory strobes, one cycle behind the control word
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            memRead  <= 1'b0;
            memWrite <= 1'b0;
        end else begin
            memRead  <= control.memRead;
            memWrite <= control.memWrite;
        end
    end

    assign memAddress   = mar;  // mar is stable through the strobe cycle
    assign memWriteData = mdr;
    assign mdrValue     = mdr;

endmodule

/* hw/fetchRegisters.sv */
`timescale 1ns/1ns
module fetchRegisters import cpuPkg::*; #(
    parameter logic [dataWidth-1:0] programStart = '0
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 start,
    input  controlWordT          control,
    input  logic [dataWidth-1:0] bus,
    output logic [dataWidth-1:0] pc,
    output instructionT          instruction
);

    // --------------------------------------------------
    // program counter
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset)
            pc <= programStart;
        else if (start)
            pc <= programStart;  // each run begins at the same place
        else if (control.pcIn)
            pc <= bus;
    end

    // instruction register, decoded only by the sequencer
    always_ff @(posedge clock) begin
        if (reset)
            instruction <= '0;
        else if (control.irIn)
            instruction <= instructionT'(bus);
    end

endmodule

/* hw/busCpu.sv */
`timescale 1ns/1ns
module busCpu import cpuPkg::*; #(
    parameter logic [dataWidth-1:0] programStart = '0
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 start,
    input  logic [dataWidth-1:0] memReadData,
    output logic [dataWidth-1:0] memAddress,
    output logic [dataWidth-1:0] memWriteData,
    output logic                 memRead,
    output logic                 memWrite,
    output logic                 busy,
    output logic                 done
);

    controlWordT          control;      // strobes for the current step
    instructionT          instruction;  // ir contents
    logic [dataWidth-1:0] bus;
    logic [dataWidth-1:0] zLow;
    logic [dataWidth-1:0] mdrValue;
    logic [dataWidth-1:0] pc;

    // --------------------------------------------------
    // control
    // --------------------------------------------------
    controlSequencer sequencer (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .instruction (instruction),
        .control     (control),
        .busy        (busy),
        .done        (done)
    );

    // --------------------------------------------------
    // datapath
    // --------------------------------------------------
    registerBus registers (
        .clock       (clock),
        .reset       (reset),
        .control     (control),
        .instruction (instruction),
        .zLow        (zLow),
        .mdrValue    (mdrValue),
        .pc          (pc),
        .bus         (bus)
    );

    aluUnit alu (
        .clock   (clock),
        .reset   (reset),
        .control (control),
        .bus     (bus),
        .zLow    (zLow)
    );

    memoryPort memory (
        .clock        (clock),
        .reset        (reset),
        .control      (control),
        .bus          (bus),
        .memReadData  (memReadData),
        .mdrValue     (mdrValue),
        .memAddress   (memAddress),
        .memWriteData (memWriteData),
        .memRead      (memRead),
        .memWrite     (memWrite)
    );

    fetchRegisters #(
        .programStart (programStart)
    ) fetch (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .control     (control),
        .bus         (bus),
        .pc          (pc),
        .instruction (instruction)
    );

endmodule

/* bench/clockGen.sv */
`timescale 1ns/1ns
module clockGen #(
    parameter int periodNs    = 100,
    parameter int resetCycles = 5
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(periodNs / 2) clock = ~clock;  // free running
    end

    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clock);   // held over five rising edges
        @(negedge clock);
        reset = 1'b0;                            // released on a falling edge
    end

endmodule

/* bench/busCpuTb.sv */
`timescale 1ns/1ns
module busCpuTb import cpuPkg::*; ();

    localparam logic [31:0] programStart = 32'd0;  // dut keeps its default
    localparam int          memWords     = 256;
    localparam logic [31:0] dataBase     = 32'd128; // data lives above the program

    logic        clock;
    logic        powerOnReset;
    logic        midRunReset;
    logic        dutReset;
    logic        start;
    logic [31:0] memReadData;
    logic [31:0] memAddress;
    logic [31:0] memWriteData;
    logic        memRead;
    logic        memWrite;
    logic        busy;
    logic        done;

    logic [31:0] mem [memWords];     // memory the dut sees
    logic [31:0] refMem [memWords];  // interpreter copy
    logic [31:0] refRegs [16];       // interpreter registers kept across runs
    logic [31:0] readLog[$];
    logic [31:0] writeLog[$];
    int          readCycleLog[$];
    logic [31:0] expectedReads[$];
    logic [31:0] expectedWrites[$];
    int          expectedCycles;
    logic [31:0] readAddress;
    logic        readPending;
    int          cycleCount;
    logic [31:0] rngState;
    logic [31:0] nextAddress;        // program builder cursor
    int          errorCount;
    int          checkCount;
    int          testCount;

    clockGen #(.periodNs(100), .resetCycles(5)) clocks (
        .clock (clock),
        .reset (powerOnReset)
    );

    assign dutReset = powerOnReset | midRunReset;

    busCpu dut (
        .clock        (clock),
        .reset        (dutReset),
        .start        (start),
        .memReadData  (memReadData),
        .memAddress   (memAddress),
        .memWriteData (memWriteData),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .busy         (busy),
        .done         (done)
    );

    // --------------------------------------------------
    // memory model sampled and driven on the falling edge
    // --------------------------------------------------
    always @(negedge clock) begin
        cycleCount++;
        memReadData = 32'hdead_0bad;            // poison outside the answer cycle
        if (readPending)
            memReadData = mem[readAddress[7:0]]; // answer one cycle after memRead
        readPending = 1'b0;
        if (memRead) begin
            if (memAddress >= memWords) begin
                errorCount++;
                $display("memory read outside the array at %0t ns, address %h",
                         $time, memAddress);
            end
            readLog.push_back(memAddress);
            readCycleLog.push_back(cycleCount);
            readAddress = memAddress;
            readPending = 1'b1;
        end
        if (memWrite) begin
            if (memAddress >= memWords) begin
                errorCount++;
                $display("memory write outside the array at %0t ns, address %h",
                         $time, memAddress);
            end
            writeLog.push_back(memAddress);
            mem[memAddress[7:0]] = memWriteData;
        end
    end

    function automatic logic [31:0] nextRandom();
        rngState ^= rngState << 13;  // xorshift32
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic failOnTimeout(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        $display("Test failures found");
        $finish;
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errorCount - errorsBefore);
    endtask

    // --------------------------------------------------
    // program building
    // --------------------------------------------------
    task automatic putWord(input logic [31:0] address, input logic [31:0] value);
        mem[address[7:0]]    = value;  // both copies stay equal until a run
        refMem[address[7:0]] = value;
    endtask

    task automatic startProgram();
        for (int i = 0; i < memWords; i++)
            putWord(32'(i), nextRandom());
        nextAddress = programStart;
    endtask

    function automatic logic [31:0] encode(input logic [4:0] op, input logic [3:0] ra,
                                           input logic [3:0] rb, input int imm);
        return {op, ra, rb, imm[18:0]};  // opcode, ra, rb, 19 bit immediate
    endfunction

    task automatic emit(input logic [4:0] op, input logic [3:0] ra, input logic [3:0] rb,
                        input int imm);
        putWord(nextAddress, encode(op, ra, rb, imm));
        nextAddress++;
    endtask

    task automatic emitAlu(input logic [4:0] op, input logic [3:0] ra, input logic [3:0] rb,
                           input logic [3:0] rc);
        emit(op, ra, rb, int'(rc) << 15);  // rc sits in the top of the immediate
    endtask

    task automatic setBase(input logic [3:0] r, input int value);
        emitAlu(opSub, r, r, r);           // clear
        emit(opAddi, r, r, value);
    endtask

    // --------------------------------------------------
    // reference interpreter
    // --------------------------------------------------
    task automatic interpret();
        logic [31:0] pcModel;
        logic [31:0] word;
        logic [31:0] immValue;
        logic [31:0] address;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [3:0]  rc;
        logic        halted;
        expectedReads.delete();
        expectedWrites.delete();
        expectedCycles = 0;
        pcModel        = programStart;
        halted         = 1'b0;
        while (!halted && expectedReads.size() < memWords) begin
            word = refMem[pcModel[7:0]];
            expectedReads.push_back(pcModel);  // fetch
            pcModel  = pcModel + 32'd1;
            ra       = word[26:23];
            rb       = word[22:19];
            rc       = word[18:15];
            immValue = {{13{word[18]}}, word[18:0]};
            address  = refRegs[rb] + immValue;
            case (word[31:27])
                opAdd:   refRegs[ra] = refRegs[rb] + refRegs[rc];
                opSub:   refRegs[ra] = refRegs[rb] - refRegs[rc];
                opAnd:   refRegs[ra] = refRegs[rb] & refRegs[rc];
                opOr:    refRegs[ra] = refRegs[rb] | refRegs[rc];
                opAddi:  refRegs[ra] = refRegs[rb] + immValue;
                opLoad: begin
                    expectedReads.push_back(address);
                    refRegs[ra] = refMem[address[7:0]];
                end
                opStore: begin
                    expectedWrites.push_back(address);
                    refMem[address[7:0]] = refRegs[ra];
                end
                default: halted = 1'b1;
            endcase
            if (halted)
                expectedCycles += 5;
            else if (word[31:27] == opLoad)
                expectedCycles += 10;
            else if (word[31:27] == opStore)
                expectedCycles += 9;
            else
                expectedCycles += 7;
        end
    endtask

    task automatic compareResults();
        checkValue("read count", readLog.size(), expectedReads.size());
        for (int i = 0; i < readLog.size() && i < expectedReads.size(); i++)
            checkValue($sformatf("read address %0d", i), readLog[i], expectedReads[i]);
        checkValue("write count", writeLog.size(), expectedWrites.size());
        for (int i = 0; i < writeLog.size() && i < expectedWrites.size(); i++)
            checkValue($sformatf("write address %0d", i), writeLog[i], expectedWrites[i]);
        for (int i = 0; i < memWords; i++)
            checkValue($sformatf("mem[%0d]", i), mem[i], refMem[i]);
    endtask

    task automatic runProgram();
        int cycles;
        interpret();
        readLog.delete();
        readCycleLog.delete();
        writeLog.delete();
        start = 1'b1;
        @(negedge clock);
        start  = 1'b0;
        cycles = 1;
        while (!done && cycles <= expectedCycles + 50) begin
            checkValue("busy", 32'(busy), 32'd1);  // high for the whole run
            @(negedge clock);
            cycles++;
        end
        if (!done) begin
            failOnTimeout("done never rose");
        end else begin
            checkValue("busy at done", 32'(busy), 32'd0);
            checkValue("cycles to done", cycles, expectedCycles + 1);
            @(negedge clock);
            checkValue("done after one cycle", 32'(done), 32'd0);
            compareResults();
        end
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic testAlu();
        int errorsBefore;
        errorsBefore = errorCount;
        startProgram();
        putWord(dataBase, 32'hffff_fff0);
        putWord(dataBase + 1, 32'h0000_0025);
        setBase(4'd15, 128);
        emit(opLoad, 4'd1, 4'd15, 0);
        emit(opLoad, 4'd2, 4'd15, 1);
        emitAlu(opAdd, 4'd3, 4'd1, 4'd2);  // wraps past zero
        emitAlu(opSub, 4'd4, 4'd2, 4'd1);
        emitAlu(opSub, 4'd5, 4'd1, 4'd2);
        emitAlu(opAnd, 4'd6, 4'd1, 4'd2);
        emitAlu(opOr, 4'd7, 4'd1, 4'd2);
        for (int r = 3; r <= 7; r++)
            emit(opStore, 4'(r), 4'd15, 16 + r);
        emit(opHalt, 4'd0, 4'd0, 0);
        runProgram();
        checkValue("wrapped sum", mem[dataBase + 19], 32'h0000_0015);
        finishTest("alu register operations", errorsBefore);
    endtask

    task automatic testAddi();
        int errorsBefore;
        errorsBefore = errorCount;
        startProgram();
        putWord(dataBase, 32'd1000);
        setBase(4'd15, 128);
        emit(opLoad, 4'd1, 4'd15, 0);
        emit(opAddi, 4'd2, 4'd1, 5);
        emit(opAddi, 4'd3, 4'd1, -1);
        emit(opAddi, 4'd4, 4'd1, -262144);  // most negative immediate
        emit(opAddi, 4'd5, 4'd1, 262143);
        emit(opAddi, 4'd6, 4'd15, -128);
        for (int r = 2; r <= 6; r++)
            emit(opStore, 4'(r), 4'd15, 32 + r);
        emit(opHalt, 4'd0, 4'd0, 0);
        runProgram();
        checkValue("addi minus one", mem[dataBase + 35], 32'd999);
        checkValue("addi most negative", mem[dataBase + 36], 32'd1000 - 32'd262144);
        checkValue("addi back to zero", mem[dataBase + 38], 32'd0);
        finishTest("addi sign extension", errorsBefore);
    endtask

    task automatic testCopy();
        int errorsBefore;
        errorsBefore = errorCount;
        startProgram();
        setBase(4'd10, 200);
        setBase(4'd11, 150);
        for (int i = 0; i < 4; i++)
            emit(opLoad, 4'(1 + i), 4'd10, i - 4);   // from 196 up
        for (int i = 0; i < 4; i++)
            emit(opStore, 4'(1 + i), 4'd11, i - 10); // to 140 up
        emit(opHalt, 4'd0, 4'd0, 0);
        runProgram();
        checkValue("copy writes", writeLog.size(), 32'd4);
        for (int i = 0; i < 4; i++) begin
            checkValue($sformatf("copy write address %0d", i), writeLog[i], 32'(140 + i));
            checkValue($sformatf("copied word %0d", i), mem[140 + i], mem[196 + i]);
        end
        finishTest("load and store", errorsBefore);
    endtask

    task automatic testControl();
        int errorsBefore;
        errorsBefore = errorCount;
        startProgram();
        emit(opAddi, 4'd1, 4'd1, 3);
        emit(opHalt, 4'd0, 4'd0, 0);
        runProgram();
        checkValue("fetch count", readLog.size(), 32'd2);
        checkValue("first fetch", readLog[0], programStart);
        checkValue("second fetch", readLog[1], programStart + 1);
        checkValue("addi cycles", 32'(readCycleLog[1] - readCycleLog[0]), 32'd7);
        finishTest("control timing", errorsBefore);
    endtask

    task automatic testRandom();
        int          errorsBefore;
        int          count;
        logic [31:0] r;
        logic [3:0]  dest;
        logic [4:0]  aluOps [4];
        errorsBefore = errorCount;
        aluOps       = '{opAdd, opSub, opAnd, opOr};
        for (int p = 0; p < 20; p++) begin
            startProgram();
            setBase(4'd15, 128);                     // r15 stays the data base
            count = 8 + int'(nextRandom() % 8);
            for (int n = 0; n < count; n++) begin
                r    = nextRandom();
                dest = r[11:8] % 4'd15;              // never overwrite r15
                case (r[1:0])
                    2'd0:    emitAlu(aluOps[r[7:6]], dest, r[15:12], r[19:16]);
                    2'd1:    emit(opAddi, dest, r[15:12], int'(r));
                    2'd2:    emit(opLoad, dest, 4'd15, int'(r[18:12]));
                    default: emit(opStore, r[11:8], 4'd15, int'(r[17:12]));
                endcase
            end
            emit(opHalt, 4'd0, 4'd0, 0);
            runProgram();
        end
        finishTest("random programs", errorsBefore);
    endtask

    task automatic testReset();
        int errorsBefore;
        errorsBefore = errorCount;
        startProgram();
        setBase(4'd15, 128);
        for (int i = 1; i <= 8; i++) begin
            emit(opAddi, 4'(i), 4'd15, i);
            emit(opStore, 4'(i), 4'd15, i);
        end
        emit(opHalt, 4'd0, 4'd0, 0);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        repeat (28) @(negedge clock);               // first store sits in T7
        checkValue("busy before reset", 32'(busy), 32'd1);
        midRunReset = 1'b1;
        @(negedge clock);                           // memWrite would have risen here
        midRunReset = 1'b0;
        checkValue("busy after reset", 32'(busy), 32'd0);
        checkValue("done after reset", 32'(done), 32'd0);
        checkValue("memRead after reset", 32'(memRead), 32'd0);
        checkValue("memWrite after reset", 32'(memWrite), 32'd0);
        for (int i = 0; i < 16; i++)
            refRegs[i] = '0;                        // dut registers cleared too
        for (int i = 0; i < memWords; i++)
            mem[i] = refMem[i];                     // undo partial stores
        runProgram();
        checkValue("refetch address", readLog[0], programStart);
        finishTest("reset mid run", errorsBefore);
    endtask

    task automatic waitForReset();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (powerOnReset && cycles < 20) begin
            @(negedge clock);
            cycles++;
        end
        if (powerOnReset)
            failOnTimeout("power-on reset never released");
        else
            @(negedge clock);
    endtask

    initial begin
        start       = 1'b0;
        midRunReset = 1'b0;
        memReadData = '0;
        readPending = 1'b0;
        readAddress = '0;
        cycleCount  = 0;
        rngState    = 32'd92;
        errorCount  = 0;
        checkCount  = 0;
        testCount   = 0;
        nextAddress = programStart;
        for (int i = 0; i < 16; i++)
            refRegs[i] = '0;
        waitForReset();
        testAlu();
        testAddi();
        testCopy();
        testControl();
        testRandom();
        testReset();
        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* files.f */
hw/cpuPkg.sv
hw/controlSequencer.sv
hw/registerBus.sv
hw/aluUnit.sv
hw/memoryPort.sv
hw/fetchRegisters.sv
hw/busCpu.sv
bench/clockGen.sv
bench/busCpuTb.sv

/* Makefile */
# Verilator build and run for the bus CPU testbench

VERILATOR  ?= verilator
TOP        ?= busCpuTb
RTL_TOP    ?= busCpu
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= -Wall
PASS_TEXT  := All tests passed!

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '$(PASS_TEXT)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
